// ==== hw/hacd_pkg.sv ====
// shared definitions for the page read path
// table geometry, page status codes and the ATT/list word layout
package hacd_pkg;

  // table geometry
  localparam int TBL_AW    = 6;              // table word index width
  localparam int TBL_DEPTH = 1 << TBL_AW;    // words in the table memory
  localparam int TBL_DW    = 20;             // bits per table word
  localparam int WAY_W     = 8;              // way number width
  localparam int STS_W     = 2;

  // host page numbers
  localparam int                HPPA_W    = 12;
  localparam logic [HPPA_W-1:0] HPPA_BASE = 12'h200;  // first valid host page

  // ATT region holds one entry per host page
  localparam int ATT_BASE    = 0;
  localparam int ATT_ENTRIES = 32;

  // list region holds the free and uncompressed list nodes
  localparam int TOL_BASE    = 32;
  localparam int TOL_ENTRIES = 31;  // last word is left unmapped

  localparam logic [TBL_AW-1:0] NULL_IDX     = '0;     // list terminator
  localparam logic [TBL_AW-1:0] UNMAPPED_IDX = 6'd63;  // hole above the list region

  // compressed slots are handed out from here upward
  localparam logic [WAY_W-1:0] CSLOT_INIT = 8'hC0;

  // page status codes
  localparam logic [STS_W-1:0] STS_DALLOC = 2'b00;
  localparam logic [STS_W-1:0] STS_UNCOMP = 2'b01;
  localparam logic [STS_W-1:0] STS_COMP   = 2'b10;

  typedef enum logic {
    TBL_RD  = 1'b0,
    TBL_UPD = 1'b1
  } tbl_op_e;

  // ATT view of a table word
  typedef struct packed {
    logic [TBL_DW-STS_W-WAY_W-1:0] spare;
    logic [STS_W-1:0]              sts;
    logic [WAY_W-1:0]              ppa;   // way when uncompressed, slot when compressed
  } att_word_t;

  // list node view of a table word
  typedef struct packed {
    logic [TBL_AW-1:0] next;   // table index of the next node, NULL_IDX ends the list
    logic [WAY_W-1:0]  way;
    logic [TBL_AW-1:0] owner;  // ATT index of the page living in this way
  } lst_word_t;

  // one stored word, decoded by region
  typedef union packed {
    att_word_t att;
    lst_word_t lst;
  } tbl_word_u;

endpackage

// ==== hw/hawk_tbl_mem.sv ====
// ATT and list table storage
// req/ack responder for reads and updates plus list head registers and a config port
`timescale 1ns/1ns

module hawk_tbl_mem import hacd_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // table port
  input  logic              tbl_req,
  input  tbl_op_e           tbl_op,
  input  logic [TBL_AW-1:0] tbl_addr,
  input  tbl_word_u         tbl_wdata,
  output logic              tbl_ack,
  output tbl_word_u         tbl_rdata,
  output logic              tbl_err,
  // list heads
  output logic [TBL_AW-1:0] free_head,
  input  logic              free_pop,
  output logic [TBL_AW-1:0] uncomp_head,
  input  logic              uncomp_pop,
  // preload port
  input  logic              cfg_we,
  input  logic [TBL_AW-1:0] cfg_addr,
  input  tbl_word_u         cfg_wdata,
  input  logic [TBL_AW-1:0] cfg_free_head,
  input  logic [TBL_AW-1:0] cfg_uncomp_head
);

  tbl_word_u mem [TBL_DEPTH];

  logic in_att;
  logic in_tol;
  logic mapped;
  logic new_req;

  assign in_att  = (tbl_addr >= TBL_AW'(ATT_BASE)) &&
                   (tbl_addr <  TBL_AW'(ATT_BASE + ATT_ENTRIES));
  assign in_tol  = (tbl_addr >= TBL_AW'(TOL_BASE)) &&
                   (tbl_addr <  TBL_AW'(TOL_BASE + TOL_ENTRIES));
  assign mapped  = in_att || in_tol;
  assign new_req = tbl_req && !tbl_ack;  // first cycle of a handshake

  // handshake and list heads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tbl_ack     <= 1'b0;
      tbl_err     <= 1'b0;
      free_head   <= NULL_IDX;
      uncomp_head <= NULL_IDX;
    end else begin
      tbl_ack <= tbl_req;               // rises a cycle after req, falls a cycle after it drops
      if (new_req) tbl_err <= !mapped;
      if (cfg_we) begin
        free_head   <= cfg_free_head;
        uncomp_head <= cfg_uncomp_head;
      end else begin
        if (free_pop)   free_head   <= tbl_rdata.lst.next;   // node read just before
        if (uncomp_pop) uncomp_head <= tbl_rdata.lst.next;
      end
    end
  end

  // storage and read data
  always_ff @(posedge clk_i) begin
    if (new_req) tbl_rdata <= mem[tbl_addr];
    if (new_req && tbl_op == TBL_UPD && mapped) begin
      mem[tbl_addr] <= tbl_wdata;       // written on the ack edge
    end else if (cfg_we) begin
      mem[cfg_addr] <= cfg_wdata;       // host preload while the manager idles
    end
  end

endmodule

// ==== hw/hawk_cmpresn_mngr.sv ====
// compression manager
// evicts the uncompressed list head into a compressed slot and returns its way
`timescale 1ns/1ns

module hawk_cmpresn_mngr import hacd_pkg::*; #(
  parameter int COMP_LAT = 6
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmp_trig,
  output logic              cmp_done,
  output logic [WAY_W-1:0]  cmp_way,
  input  logic [TBL_AW-1:0] uncomp_head,
  output logic              uncomp_pop,
  output logic              cm_req,
  output tbl_op_e           cm_op,
  output logic [TBL_AW-1:0] cm_addr,
  output tbl_word_u         cm_wdata,
  input  logic              tbl_ack,
  input  tbl_word_u         tbl_rdata
);

  localparam int CNT_W = $clog2(COMP_LAT) + 1;

  typedef enum logic [2:0] {C_IDLE, C_RD_LST, C_WAIT_LST, C_ENGINE, C_WR_ATT} cstate_e;

  cstate_e           state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [WAY_W-1:0]  slot_q;     // next free compressed slot
  logic [TBL_AW-1:0] owner_q;    // ATT index of the evicted page

  assign uncomp_pop = (state_q == C_WAIT_LST) && cm_req && tbl_ack;
  assign cm_op      = (state_q == C_WR_ATT) ? TBL_UPD : TBL_RD;
  assign cm_addr    = (state_q == C_WR_ATT) ? owner_q : uncomp_head;

  always_comb begin
    cm_wdata         = '0;
    cm_wdata.att.sts = STS_COMP;
    cm_wdata.att.ppa = slot_q;   // page now lives in this slot
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= C_IDLE;
      cnt_q    <= '0;
      slot_q   <= CSLOT_INIT;
      cm_req   <= 1'b0;
      cmp_done <= 1'b0;
    end else begin
      cmp_done <= 1'b0;
      case (state_q)
        C_IDLE:     if (cmp_trig && !cmp_done) state_q <= C_RD_LST;  // trig still high on done
        C_RD_LST:   if (!tbl_ack) begin
          cm_req  <= 1'b1;
          state_q <= C_WAIT_LST;
        end
        C_WAIT_LST: if (cm_req && tbl_ack) begin
          cm_req  <= 1'b0;
          cnt_q   <= CNT_W'(COMP_LAT - 1);
          state_q <= C_ENGINE;
        end
        C_ENGINE: begin                 // engine latency, no data moves
          if (cnt_q == '0) state_q <= C_WR_ATT;
          else cnt_q <= cnt_q - 1'b1;
        end
        C_WR_ATT: begin
          if (!cm_req && !tbl_ack) begin
            cm_req <= 1'b1;
          end else if (cm_req && tbl_ack) begin
            cm_req   <= 1'b0;
            slot_q   <= slot_q + 1'b1;
            cmp_done <= 1'b1;
            state_q  <= C_IDLE;
          end
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  // evicted node payload
  always_ff @(posedge clk_i) begin
    if (uncomp_pop) begin
      cmp_way <= tbl_rdata.lst.way;
      owner_q <= tbl_rdata.lst.owner;
    end
  end

endmodule

// ==== hw/hawk_decomp_mngr.sv ====
// decompression manager
// waits out the engine latency then maps the expanded page's ATT entry to its new way
`timescale 1ns/1ns

module hawk_decomp_mngr import hacd_pkg::*; #(
  parameter int DECOMP_LAT = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dcmp_trig,
  input  logic [WAY_W-1:0]  dcmp_way,
  input  logic [TBL_AW-1:0] dcmp_att_idx,
  output logic              dcmp_done,
  output logic              dm_req,
  output tbl_op_e           dm_op,
  output logic [TBL_AW-1:0] dm_addr,
  output tbl_word_u         dm_wdata,
  input  logic              tbl_ack
);

  localparam int CNT_W = $clog2(DECOMP_LAT) + 1;

  typedef enum logic [1:0] {D_IDLE, D_ENGINE, D_WR_ATT} dstate_e;

  dstate_e          state_q;
  logic [CNT_W-1:0] cnt_q;

  // trigger fields stay stable while the manager waits
  assign dm_op   = TBL_UPD;           // only ever writes
  assign dm_addr = dcmp_att_idx;

  always_comb begin
    dm_wdata         = '0;
    dm_wdata.att.sts = STS_UNCOMP;
    dm_wdata.att.ppa = dcmp_way;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= D_IDLE;
      cnt_q     <= '0;
      dm_req    <= 1'b0;
      dcmp_done <= 1'b0;
    end else begin
      dcmp_done <= 1'b0;
      case (state_q)
        D_IDLE: if (dcmp_trig && !dcmp_done) begin
          cnt_q   <= CNT_W'(DECOMP_LAT - 1);
          state_q <= D_ENGINE;
        end
        D_ENGINE: begin
          if (cnt_q == '0) state_q <= D_WR_ATT;
          else cnt_q <= cnt_q - 1'b1;
        end
        D_WR_ATT: begin
          if (!dm_req && !tbl_ack) begin
            dm_req <= 1'b1;
          end else if (dm_req && tbl_ack) begin
            dm_req    <= 1'b0;
            dcmp_done <= 1'b1;       // single pulse back to the manager
            state_q   <= D_IDLE;
          end
        end
        default: state_q <= D_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/hawk_pgrd_mngr.sv ====
// page read manager
// walks the ATT for each host lookup, gets a way from the free list or by eviction
// and shares the table port with the compression and decompression managers
`timescale 1ns/1ns

module hawk_pgrd_mngr import hacd_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // host lookup port
  input  logic              lkup_req,
  input  logic [HPPA_W-1:0] lkup_hppa,
  output logic              lkup_ack,
  output logic [WAY_W-1:0]  trnsl_ppa,
  output logic [STS_W-1:0]  trnsl_sts,
  output logic              trnsl_err,
  output logic              mgr_ready,
  // table port
  output logic              tbl_req,
  output tbl_op_e           tbl_op,
  output logic [TBL_AW-1:0] tbl_addr,
  output tbl_word_u         tbl_wdata,
  input  logic              tbl_ack,
  input  tbl_word_u         tbl_rdata,
  input  logic              tbl_err,
  input  logic [TBL_AW-1:0] free_head,
  output logic              free_pop,
  // compression manager
  output logic              cmp_trig,
  input  logic              cmp_done,
  input  logic [WAY_W-1:0]  cmp_way,
  input  logic              cm_req,
  input  tbl_op_e           cm_op,
  input  logic [TBL_AW-1:0] cm_addr,
  input  tbl_word_u         cm_wdata,
  // decompression manager
  output logic              dcmp_trig,
  output logic [WAY_W-1:0]  dcmp_way,
  output logic [TBL_AW-1:0] dcmp_att_idx,
  input  logic              dcmp_done,
  input  logic              dm_req,
  input  tbl_op_e           dm_op,
  input  logic [TBL_AW-1:0] dm_addr,
  input  tbl_word_u         dm_wdata
);

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP_ATT,
    WAIT_ATT,
    DECODE,
    POP_FREE,
    WAIT_LST,
    TBL_UPDATE,
    COMPRESS,
    DECOMPRESS,
    RESPOND,
    BUS_ERROR
  } state_e;

  state_e            state_q;
  logic              own_req_q;   // manager's own table request
  logic [TBL_AW-1:0] att_idx_q;   // ATT index of the page being served
  tbl_word_u         att_q;       // ATT entry as read
  logic [WAY_W-1:0]  way_q;       // way obtained for the page

  logic [HPPA_W-1:0] hppa_ofs;
  logic              hppa_ok;
  logic              own_done;    // own handshake completes this cycle
  tbl_op_e           own_op;
  logic [TBL_AW-1:0] own_addr;
  tbl_word_u         own_wdata;

  assign hppa_ofs = lkup_hppa - HPPA_BASE;     // pages below the base wrap high
  assign hppa_ok  = hppa_ofs < HPPA_W'(ATT_ENTRIES);
  assign own_done = own_req_q && tbl_ack;

  // own request fields follow the state
  assign own_op   = (state_q == TBL_UPDATE) ? TBL_UPD : TBL_RD;
  assign own_addr = (state_q == POP_FREE || state_q == WAIT_LST) ? free_head : att_idx_q;

  always_comb begin
    own_wdata         = '0;
    own_wdata.att.sts = STS_UNCOMP;  // new entry always maps the obtained way
    own_wdata.att.ppa = way_q;
  end

  // table port requester mux
  always_comb begin
    case (state_q)
      COMPRESS: begin
        tbl_req   = cm_req;
        tbl_op    = cm_op;
        tbl_addr  = cm_addr;
        tbl_wdata = cm_wdata;
      end
      DECOMPRESS: begin
        tbl_req   = dm_req;
        tbl_op    = dm_op;
        tbl_addr  = dm_addr;
        tbl_wdata = dm_wdata;
      end
      default: begin
        tbl_req   = own_req_q;
        tbl_op    = own_op;
        tbl_addr  = own_addr;
        tbl_wdata = own_wdata;
      end
    endcase
  end

  assign free_pop     = (state_q == WAIT_LST) && own_done;  // head moves to next node
  assign cmp_trig     = (state_q == COMPRESS);
  assign dcmp_trig    = (state_q == DECOMPRESS);
  assign dcmp_way     = way_q;
  assign dcmp_att_idx = att_idx_q;

  // control FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      own_req_q <= 1'b0;
      lkup_ack  <= 1'b0;
      trnsl_err <= 1'b0;
      mgr_ready <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          mgr_ready <= !lkup_req;
          if (lkup_req) state_q <= LOOKUP_ATT;
        end
        LOOKUP_ATT: if (!tbl_ack) begin  // previous handshake fully closed
          own_req_q <= 1'b1;
          state_q   <= WAIT_ATT;
        end
        WAIT_ATT: if (own_done) begin
          own_req_q <= 1'b0;
          trnsl_err <= tbl_err;
          state_q   <= tbl_err ? BUS_ERROR : DECODE;
        end
        DECODE: begin
          case (att_q.att.sts)
            STS_UNCOMP:           state_q <= RESPOND;   // hit
            STS_DALLOC, STS_COMP: state_q <= POP_FREE;  // both need a way first
            default: begin                              // reserved code is a corrupt entry
              trnsl_err <= 1'b1;
              state_q   <= BUS_ERROR;
            end
          endcase
        end
        POP_FREE: begin
          if (free_head == NULL_IDX) begin
            state_q <= COMPRESS;          // evict to free a way
          end else if (!tbl_ack) begin
            own_req_q <= 1'b1;
            state_q   <= WAIT_LST;
          end
        end
        WAIT_LST: if (own_done) begin
          own_req_q <= 1'b0;
          if (tbl_err) begin
            trnsl_err <= 1'b1;
            state_q   <= BUS_ERROR;
          end else begin
            state_q <= (att_q.att.sts == STS_COMP) ? DECOMPRESS : TBL_UPDATE;
          end
        end
        TBL_UPDATE: begin
          if (!own_req_q && !tbl_ack) begin
            own_req_q <= 1'b1;
          end else if (own_done) begin
            own_req_q <= 1'b0;
            trnsl_err <= tbl_err;
            state_q   <= tbl_err ? BUS_ERROR : RESPOND;
          end
        end
        COMPRESS: if (cmp_done) begin
          state_q <= (att_q.att.sts == STS_COMP) ? DECOMPRESS : TBL_UPDATE;
        end
        DECOMPRESS: if (dcmp_done) state_q <= RESPOND;  // ATT already rewritten
        RESPOND: begin
          if (!lkup_ack) begin
            lkup_ack <= 1'b1;
          end else if (!lkup_req) begin   // hold ack until the host lets go
            lkup_ack <= 1'b0;
            state_q  <= IDLE;
          end
        end
        BUS_ERROR: begin                  // sticky, every lookup answered with err
          if (lkup_req && !lkup_ack) lkup_ack <= 1'b1;
          else if (!lkup_req && lkup_ack) lkup_ack <= 1'b0;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // lookup context and response
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && lkup_req) begin
      att_idx_q <= hppa_ok ? TBL_AW'(ATT_BASE) + hppa_ofs[TBL_AW-1:0] : UNMAPPED_IDX;
    end
    if (state_q == WAIT_ATT && own_done) att_q <= tbl_rdata;
    if (free_pop) begin
      way_q <= tbl_rdata.lst.way;
    end else if (state_q == COMPRESS && cmp_done) begin
      way_q <= cmp_way;                   // evicted page's way
    end
    if (state_q == DECODE) begin
      trnsl_ppa <= att_q.att.ppa;
      trnsl_sts <= att_q.att.sts;
    end else if (state_q == TBL_UPDATE || state_q == DECOMPRESS) begin
      trnsl_ppa <= way_q;
      trnsl_sts <= STS_UNCOMP;
    end
  end

endmodule

// ==== hw/hawk_pgrd_top.sv ====
// page read subsystem top
// lookup manager, compression and decompression managers around the table memory
`timescale 1ns/1ns

module hawk_pgrd_top import hacd_pkg::*; #(
  parameter int COMP_LAT   = 6,
  parameter int DECOMP_LAT = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lkup_req,
  input  logic [HPPA_W-1:0] lkup_hppa,
  output logic              lkup_ack,
  output logic [WAY_W-1:0]  trnsl_ppa,
  output logic [STS_W-1:0]  trnsl_sts,
  output logic              trnsl_err,
  output logic              mgr_ready,
  input  logic              cfg_we,
  input  logic [TBL_AW-1:0] cfg_addr,
  input  tbl_word_u         cfg_wdata,
  input  logic [TBL_AW-1:0] cfg_free_head,
  input  logic [TBL_AW-1:0] cfg_uncomp_head
);

  // shared table port
  logic              tbl_req;
  tbl_op_e           tbl_op;
  logic [TBL_AW-1:0] tbl_addr;
  tbl_word_u         tbl_wdata;
  logic              tbl_ack;
  tbl_word_u         tbl_rdata;
  logic              tbl_err;

  // list heads
  logic [TBL_AW-1:0] free_head;
  logic              free_pop;
  logic [TBL_AW-1:0] uncomp_head;
  logic              uncomp_pop;

  // compression manager side
  logic              cmp_trig;
  logic              cmp_done;
  logic [WAY_W-1:0]  cmp_way;
  logic              cm_req;
  tbl_op_e           cm_op;
  logic [TBL_AW-1:0] cm_addr;
  tbl_word_u         cm_wdata;

  // decompression manager side
  logic              dcmp_trig;
  logic [WAY_W-1:0]  dcmp_way;
  logic [TBL_AW-1:0] dcmp_att_idx;
  logic              dcmp_done;
  logic              dm_req;
  tbl_op_e           dm_op;
  logic [TBL_AW-1:0] dm_addr;
  tbl_word_u         dm_wdata;

  hawk_pgrd_mngr u_pgrd_mngr (.*);

  hawk_tbl_mem u_tbl_mem (.*);

  hawk_cmpresn_mngr #(.COMP_LAT(COMP_LAT)) u_cmpresn_mngr (.*);

  hawk_decomp_mngr #(.DECOMP_LAT(DECOMP_LAT)) u_decomp_mngr (.*);

endmodule

// ==== testbench/tb_clk_gen.sv ====
// clock and reset generator for the page read testbench
// reset is held for a fixed number of cycles at start and again on request
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD  = 8,   // ns
  parameter int RST_CYC = 8
) (
  output logic clk,
  output logic rst_n,
  input  logic rst_req         // one-cycle pulse restarts the reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    forever begin
      @(posedge clk);
      if (rst_req) begin
        rst_n <= 1'b0;                   // async assert, released on an edge
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
      end
    end
  end

endmodule

// ==== testbench/hawk_pgrd_assert.sv ====
// protocol checks on the page read manager
// table handshake, lookup ack and compression done pulse
`timescale 1ns/1ns

module hawk_pgrd_assert import hacd_pkg::*; (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              tbl_req,
  input logic              tbl_ack,
  input logic [TBL_AW-1:0] tbl_addr,
  input logic              lkup_req,
  input logic              lkup_ack,
  input logic              cmp_trig,
  input logic              cmp_done
);

  int fail_cnt = 0;  // assertion failures so far

  // requester keeps req up until the responder acks
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_req && !tbl_ack |=> tbl_req)
    else begin
      fail_cnt++;
      $error("tbl_req dropped before tbl_ack");
    end

  // index may not move inside a handshake
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_req && $past(tbl_req) |-> $stable(tbl_addr))
    else begin
      fail_cnt++;
      $error("tbl_addr changed while tbl_req was high");
    end

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(lkup_ack) |-> lkup_req)
    else begin
      fail_cnt++;
      $error("lkup_ack rose with no lookup pending");
    end

  // one done per eviction, the trigger drops right after it
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_done |-> cmp_trig ##1 (!cmp_done && !cmp_trig))
    else begin
      fail_cnt++;
      $error("cmp_done was not a single pulse ending the compression trigger");
    end

endmodule

bind hawk_pgrd_mngr hawk_pgrd_assert u_prot_assert (.*);

// ==== testbench/tb_hawk_pgrd.sv ====
// testbench for the page read subsystem
// directed lookups checked against a model of the ATT, free list and uncompressed list
`timescale 1ns/1ns

module tb_hawk_pgrd import hacd_pkg::*; ();

  localparam int COMP_LAT    = 6;
  localparam int DECOMP_LAT  = 4;
  localparam int N_LKUP      = 14;                          // lookups over all tests
  localparam int WORST_LKUP  = 24 + COMP_LAT + DECOMP_LAT;  // eviction plus expansion
  localparam int SETUP_CYC   = TBL_DEPTH + 3 * 16;          // preload and resets
  localparam int CYCLE_LIMIT = 20 * (N_LKUP * WORST_LKUP + SETUP_CYC);
  localparam int HIT_PAGE    = 1;                           // never on the uncompressed list
  localparam int FREE_NODE   = TOL_BASE;                    // free list nodes 32..34
  localparam int UNC_NODE    = TOL_BASE + 8;                // uncompressed nodes 40..42

  logic              clk_i;
  logic              rst_ni;
  logic              rst_req;
  logic              lkup_req;
  logic [HPPA_W-1:0] lkup_hppa;
  logic              lkup_ack;
  logic [WAY_W-1:0]  trnsl_ppa;
  logic [STS_W-1:0]  trnsl_sts;
  logic              trnsl_err;
  logic              mgr_ready;
  logic              cfg_we;
  logic [TBL_AW-1:0] cfg_addr;
  tbl_word_u         cfg_wdata;
  logic [TBL_AW-1:0] cfg_free_head;
  logic [TBL_AW-1:0] cfg_uncomp_head;

  // reference model
  tbl_word_u         ref_tbl [TBL_DEPTH];
  logic [WAY_W-1:0]  free_q [$];
  logic [WAY_W-1:0]  unc_way_q [$];
  logic [TBL_AW-1:0] unc_own_q [$];   // owner ATT index per uncompressed node
  logic [WAY_W-1:0]  ref_slot;
  logic              ref_err;         // sticky bus error
  bit                way_used [256];
  logic [31:0]       rng;

  int err_cnt   = 0;
  int chk_cnt   = 0;
  int test_cnt  = 0;
  int test_fail = 0;
  int cycles    = 0;
  int sva_fails;

  tb_clk_gen #(.PERIOD(8), .RST_CYC(8)) u_clk_gen (.clk(clk_i), .rst_n(rst_ni), .rst_req(rst_req));

  hawk_pgrd_top #(.COMP_LAT(COMP_LAT), .DECOMP_LAT(DECOMP_LAT)) DUT (.*);

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: DUT made no progress within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic tbl_word_u make_att(input logic [STS_W-1:0] sts, input logic [WAY_W-1:0] ppa);
    tbl_word_u w;
    w         = '0;
    w.att.sts = sts;
    w.att.ppa = ppa;
    return w;
  endfunction

  function automatic logic [HPPA_W-1:0] hppa_of(input int idx);
    return HPPA_BASE + HPPA_W'(idx);
  endfunction

  task automatic pick_way(output logic [WAY_W-1:0] way);
    do begin
      rng = next_rand(rng);
      way = WAY_W'(rng % 192);        // keep clear of the slot range
    end while (way_used[way]);
    way_used[way] = 1'b1;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("Fail %0t: %s = %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  // model contents, all other pages start deallocated
  task automatic build_table();
    tbl_word_u        w;
    logic [WAY_W-1:0] way;
    rng = 32'd42692;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      ref_tbl[i] = '0;
    end
    pick_way(way);
    ref_tbl[ATT_BASE + HIT_PAGE] = make_att(STS_UNCOMP, way);
    ref_tbl[ATT_BASE + 5] = make_att(STS_COMP, 8'hB0);   // already compressed pages
    ref_tbl[ATT_BASE + 6] = make_att(STS_COMP, 8'hB1);
    for (int n = 0; n < 3; n++) begin
      pick_way(way);
      free_q.push_back(way);
      w          = '0;
      w.lst.next = (n == 2) ? NULL_IDX : TBL_AW'(FREE_NODE + n + 1);
      w.lst.way  = way;
      ref_tbl[FREE_NODE + n] = w;
    end
    for (int n = 0; n < 3; n++) begin
      pick_way(way);
      unc_way_q.push_back(way);
      unc_own_q.push_back(TBL_AW'(2 + n));                // pages 2..4 own these ways
      w           = '0;
      w.lst.next  = (n == 2) ? NULL_IDX : TBL_AW'(UNC_NODE + n + 1);
      w.lst.way   = way;
      w.lst.owner = TBL_AW'(2 + n);
      ref_tbl[UNC_NODE + n] = w;
      ref_tbl[ATT_BASE + 2 + n] = make_att(STS_UNCOMP, way);
    end
    ref_slot = CSLOT_INIT;
    ref_err  = 1'b0;
  endtask

  task automatic reset_model();
    free_q.delete();                  // heads come back as NULL
    unc_way_q.delete();
    unc_own_q.delete();
    ref_slot = CSLOT_INIT;
    ref_err  = 1'b0;
  endtask

  task automatic preload_table();
    for (int a = 0; a < TBL_DEPTH; a++) begin
      @(posedge clk_i);
      cfg_we          <= 1'b1;
      cfg_addr        <= TBL_AW'(a);
      cfg_wdata       <= ref_tbl[a];
      cfg_free_head   <= TBL_AW'(FREE_NODE);
      cfg_uncomp_head <= TBL_AW'(UNC_NODE);
    end
    @(posedge clk_i);
    cfg_we <= 1'b0;
  endtask

  // expected answer, updates the model like the lookup would
  task automatic predict(input logic [HPPA_W-1:0] hppa, output logic [WAY_W-1:0] ppa,
                         output logic [STS_W-1:0] sts, output logic err);
    logic [HPPA_W-1:0] ofs;
    tbl_word_u         e;
    logic [WAY_W-1:0]  way;
    logic [TBL_AW-1:0] owner;
    ofs = hppa - HPPA_BASE;
    ppa = '0;
    sts = STS_UNCOMP;
    err = 1'b0;
    if (ref_err || ofs >= HPPA_W'(ATT_ENTRIES)) begin
      ref_err = 1'b1;
      err     = 1'b1;
    end else begin
      e = ref_tbl[ATT_BASE + ofs];
      if (e.att.sts == STS_UNCOMP) begin
        ppa = e.att.ppa;                                 // hit
      end else begin
        if (free_q.size() > 0) begin
          way = free_q.pop_front();
        end else begin
          way   = unc_way_q.pop_front();                 // evict the oldest page
          owner = unc_own_q.pop_front();
          ref_tbl[ATT_BASE + owner] = make_att(STS_COMP, ref_slot);
          ref_slot = ref_slot + 1'b1;
        end
        ref_tbl[ATT_BASE + ofs] = make_att(STS_UNCOMP, way);
        ppa = way;
      end
    end
  endtask

  task automatic run_lookup(input logic [HPPA_W-1:0] hppa);
    logic [WAY_W-1:0] exp_ppa;
    logic [STS_W-1:0] exp_sts;
    logic             exp_err;
    predict(hppa, exp_ppa, exp_sts, exp_err);
    @(posedge clk_i);
    lkup_req  <= 1'b1;
    lkup_hppa <= hppa;
    @(negedge clk_i);
    while (!lkup_ack) @(negedge clk_i);
    check_val("trnsl_err", trnsl_err, exp_err);
    if (!exp_err) begin
      check_val("trnsl_ppa", trnsl_ppa, exp_ppa);
      check_val("trnsl_sts", trnsl_sts, exp_sts);
    end
    @(posedge clk_i);
    lkup_req <= 1'b0;
    @(negedge clk_i);
    while (lkup_ack) @(negedge clk_i);   // four-phase close
  endtask

  task automatic test_reset_hit(input string name, input bit load);
    int e0;
    e0 = err_cnt;
    @(negedge clk_i);
    while (!rst_ni) begin
      check_val("lkup_ack", lkup_ack, 0);
      check_val("trnsl_err", trnsl_err, 0);
      check_val("mgr_ready", mgr_ready, 0);
      @(negedge clk_i);
    end
    while (!mgr_ready) @(negedge clk_i);
    check_val("lkup_ack", lkup_ack, 0);
    check_val("trnsl_err", trnsl_err, 0);
    if (load) preload_table();
    run_lookup(hppa_of(HIT_PAGE));
    end_test(name, e0);
  endtask

  task automatic test_free_alloc();
    int e0;
    e0 = err_cnt;
    run_lookup(hppa_of(10));           // first free way
    run_lookup(hppa_of(11));
    run_lookup(hppa_of(10));           // now a hit on the same way
    end_test("free_alloc", e0);
  endtask

  task automatic test_comp_page();
    int e0;
    e0 = err_cnt;
    run_lookup(hppa_of(5));            // last free way, then expanded
    run_lookup(hppa_of(5));
    end_test("comp_page", e0);
  endtask

  task automatic test_evict();
    int e0;
    e0 = err_cnt;
    run_lookup(hppa_of(12));           // free list empty, page 2 evicted
    run_lookup(hppa_of(2));            // evicted owner comes back via page 3
    run_lookup(hppa_of(2));
    run_lookup(hppa_of(6));            // compressed page through eviction of page 4
    end_test("evict", e0);
  endtask

  task automatic test_bus_error();
    int e0;
    e0 = err_cnt;
    run_lookup(hppa_of(ATT_ENTRIES));  // first page past the table
    check_val("mgr_ready", mgr_ready, 0);
    run_lookup(HPPA_BASE - 1'b1);      // below the base
    run_lookup(hppa_of(HIT_PAGE));     // valid page still refused
    repeat (2) @(negedge clk_i);
    check_val("mgr_ready", mgr_ready, 0);
    check_val("trnsl_err", trnsl_err, 1);
    end_test("bus_error", e0);
    @(posedge clk_i);
    rst_req <= 1'b1;
    @(posedge clk_i);
    rst_req <= 1'b0;
    reset_model();
  endtask

  initial begin
    rst_req         = 1'b0;
    lkup_req        = 1'b0;
    lkup_hppa       = '0;
    cfg_we          = 1'b0;
    cfg_addr        = '0;
    cfg_wdata       = '0;
    cfg_free_head   = '0;
    cfg_uncomp_head = '0;
    build_table();
    test_reset_hit("reset_hit", 1'b1);
    test_free_alloc();
    test_comp_page();
    test_evict();
    test_bus_error();
    test_reset_hit("reset_hit_again", 1'b0);   // table kept, heads cleared
    sva_fails = DUT.u_pgrd_mngr.u_prot_assert.fail_cnt;
    $display("tests %0d, failed tests %0d, checks %0d, check errors %0d, assertion errors %0d",
             test_cnt, test_fail, chk_cnt, err_cnt, sva_fails);
    if (err_cnt == 0 && sva_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/hacd_pkg.sv
hw/hawk_tbl_mem.sv
hw/hawk_cmpresn_mngr.sv
hw/hawk_decomp_mngr.sv
hw/hawk_pgrd_mngr.sv
hw/hawk_pgrd_top.sv
testbench/tb_clk_gen.sv
testbench/hawk_pgrd_assert.sv
testbench/tb_hawk_pgrd.sv
